// File: common/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [29:0] wordAddrT;    // Data port addresses words
    typedef logic [4:0]  regIdxT;

    localparam wordT resetVector = 32'h0000_0000;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // Function codes under opSpecial
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu, aluLui
    } aluOpT;

    typedef enum logic [1:0] {fwdRegister, fwdMemory, fwdWriteback} fwdSelT;

    typedef enum logic [1:0] {pcSequential, pcBranch, pcJump} pcSelT;

    typedef struct packed {
        aluOpT  aluOp;
        logic   aluSrcImm;
        logic   memRead;
        logic   memWrite;
        logic   regWrite;
        logic   memToReg;
        regIdxT rs;
        regIdxT rt;
        regIdxT dest;
        wordT   rsValue;
        wordT   rtValue;
        wordT   imm;        // Already sign or zero extended
    } idExT;

    typedef struct packed {
        logic   memRead;
        logic   memWrite;
        logic   regWrite;
        logic   memToReg;
        regIdxT dest;
        wordT   aluResult;
        wordT   storeData;
    } exMemT;

    typedef struct packed {
        logic   regWrite;
        regIdxT dest;
        wordT   value;
    } memWbT;

    // Operand mux shared by the decode and execute forwarding paths
    function automatic wordT pickOperand(fwdSelT sel, wordT regValue, wordT memValue,
                                         wordT wbValue);
        case (sel)
            fwdMemory:    return memValue;
            fwdWriteback: return wbValue;
            default:      return regValue;
        endcase
    endfunction

endpackage

// File: rtl/fetchStage.sv
`timescale 1ns/10ps

module fetchStage (
    input  logic            clock,
    input  logic            rstN,
    input  logic            fetchHold,
    input  logic            pipeFreeze,
    input  mipsPkg::pcSelT  pcSel,
    input  mipsPkg::wordT   branchTarget,
    input  mipsPkg::wordT   jumpTarget,
    input  mipsPkg::wordT   instData,
    input  logic            instStall,
    output mipsPkg::wordT   instAddress,
    output mipsPkg::wordT   decodeInst,
    output mipsPkg::wordT   decodePcPlus4
);

    mipsPkg::wordT pc;
    mipsPkg::wordT pcPlus4;
    mipsPkg::wordT nextPc;
    logic          advance;

    assign pcPlus4     = pc + 32'd4;
    assign advance     = ~(fetchHold | pipeFreeze);
    assign instAddress = pc;

    // Redirect comes from the instruction now in decode
    always_comb begin
        case (pcSel)
            mipsPkg::pcBranch: nextPc = branchTarget;
            mipsPkg::pcJump:   nextPc = jumpTarget;
            default:           nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc <= mipsPkg::resetVector;
        end else if (advance) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            decodeInst    <= '0;    // All-zero word decodes as a nop
            decodePcPlus4 <= '0;
        end else if (advance) begin
            decodeInst    <= instStall ? '0 : instData;   // Busy port gives a bubble
            decodePcPlus4 <= pcPlus4;
        end
    end

endmodule

// File: decode/decodeControl.sv
`timescale 1ns/10ps

module decodeControl (
    input  logic             clock,
    input  logic             rstN,
    input  mipsPkg::wordT    decodeInst,
    input  mipsPkg::wordT    decodePcPlus4,
    input  mipsPkg::wordT    rsValue,
    input  mipsPkg::wordT    rtValue,
    input  mipsPkg::fwdSelT  rsFwd,
    input  mipsPkg::fwdSelT  rtFwd,
    input  mipsPkg::wordT    memResult,
    input  mipsPkg::wordT    wbResult,
    input  logic             decodeBubble,
    input  logic             pipeFreeze,
    output mipsPkg::regIdxT  rsIdx,
    output mipsPkg::regIdxT  rtIdx,
    output logic             rsUsed,
    output logic             rtUsed,
    output logic             isBranch,
    output mipsPkg::pcSelT   pcSel,
    output mipsPkg::wordT    branchTarget,
    output mipsPkg::wordT    jumpTarget,
    output mipsPkg::idExT    idEx
);

    logic [5:0]      opcode;
    logic [5:0]      funct;
    logic [15:0]     imm16;
    mipsPkg::wordT   signImm;
    mipsPkg::wordT   rsFwdValue;
    mipsPkg::wordT   rtFwdValue;
    mipsPkg::idExT   idExNext;
    logic            isJump;
    logic            branchTaken;

    assign opcode  = decodeInst[31:26];
    assign funct   = decodeInst[5:0];
    assign imm16   = decodeInst[15:0];
    assign rsIdx   = decodeInst[25:21];
    assign rtIdx   = decodeInst[20:16];
    assign signImm = {{16{imm16[15]}}, imm16};

    assign branchTarget = decodePcPlus4 + {signImm[29:0], 2'b00};
    assign jumpTarget   = {decodePcPlus4[31:28], decodeInst[25:0], 2'b00};

    assign rsFwdValue = mipsPkg::pickOperand(rsFwd, rsValue, memResult, wbResult);
    assign rtFwdValue = mipsPkg::pickOperand(rtFwd, rtValue, memResult, wbResult);

    // bne inverts the equality test
    assign branchTaken = isBranch & ((rsFwdValue == rtFwdValue) ^ (opcode == mipsPkg::opBne));
    assign pcSel = isJump ? mipsPkg::pcJump :
                   (branchTaken ? mipsPkg::pcBranch : mipsPkg::pcSequential);

    always_comb begin
        idExNext         = '0;
        idExNext.rs      = rsIdx;
        idExNext.rt      = rtIdx;
        idExNext.dest    = rtIdx;           // I-type default
        idExNext.rsValue = rsFwdValue;
        idExNext.rtValue = rtFwdValue;
        idExNext.imm     = signImm;
        rsUsed   = 1'b0;
        rtUsed   = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        case (opcode)
            mipsPkg::opSpecial: begin
                rsUsed            = 1'b1;
                rtUsed            = 1'b1;
                idExNext.dest     = decodeInst[15:11];
                idExNext.regWrite = 1'b1;
                case (funct)
                    mipsPkg::fnAddu: idExNext.aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: idExNext.aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  idExNext.aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   idExNext.aluOp = mipsPkg::aluOr;
                    mipsPkg::fnXor:  idExNext.aluOp = mipsPkg::aluXor;
                    mipsPkg::fnSlt:  idExNext.aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnSltu: idExNext.aluOp = mipsPkg::aluSltu;
                    default: begin
                        idExNext.regWrite = 1'b0;   // Nop and unsupported functs
                        rsUsed            = 1'b0;
                        rtUsed            = 1'b0;
                    end
                endcase
            end
            mipsPkg::opAddiu, mipsPkg::opLw: begin
                rsUsed             = 1'b1;
                idExNext.aluSrcImm = 1'b1;
                idExNext.regWrite  = 1'b1;
                idExNext.memRead   = (opcode == mipsPkg::opLw);
                idExNext.memToReg  = (opcode == mipsPkg::opLw);
            end
            mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opLui: begin
                rsUsed             = (opcode != mipsPkg::opLui);
                idExNext.aluSrcImm = 1'b1;
                idExNext.regWrite  = 1'b1;
                idExNext.imm       = {16'h0000, imm16};
                idExNext.aluOp     = (opcode == mipsPkg::opAndi) ? mipsPkg::aluAnd :
                                     (opcode == mipsPkg::opOri) ? mipsPkg::aluOr : mipsPkg::aluLui;
            end
            mipsPkg::opSw: begin
                rsUsed             = 1'b1;
                rtUsed             = 1'b1;      // Store data
                idExNext.aluSrcImm = 1'b1;
                idExNext.memWrite  = 1'b1;
            end
            mipsPkg::opBeq, mipsPkg::opBne: begin
                rsUsed   = 1'b1;
                rtUsed   = 1'b1;
                isBranch = 1'b1;
            end
            mipsPkg::opJ: isJump = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            idEx <= '0;
        end else if (!pipeFreeze) begin
            idEx <= decodeBubble ? '0 : idExNext;
        end
    end

endmodule

// File: decode/registerFile.sv
`timescale 1ns/10ps

module registerFile (
    input  logic            clock,
    input  logic            rstN,
    input  mipsPkg::regIdxT rsIdx,
    input  mipsPkg::regIdxT rtIdx,
    input  mipsPkg::memWbT  memWb,
    output mipsPkg::wordT   rsValue,
    output mipsPkg::wordT   rtValue
);

    mipsPkg::wordT regs [1:31];    // Register zero is not stored
    logic          writeEn;

    assign writeEn = memWb.regWrite && (memWb.dest != '0);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[memWb.dest] <= memWb.value;
        end
    end

    // Same-cycle write shows through to decode
    assign rsValue = (rsIdx == '0) ? '0 :
                     (writeEn && memWb.dest == rsIdx) ? memWb.value : regs[rsIdx];
    assign rtValue = (rtIdx == '0) ? '0 :
                     (writeEn && memWb.dest == rtIdx) ? memWb.value : regs[rtIdx];

endmodule

// File: rtl/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    input  mipsPkg::regIdxT  rsIdx,
    input  mipsPkg::regIdxT  rtIdx,
    input  logic             rsUsed,
    input  logic             rtUsed,
    input  logic             isBranch,
    input  mipsPkg::idExT    idEx,
    input  mipsPkg::exMemT   exMem,
    input  mipsPkg::memWbT   memWb,
    input  logic             instStall,
    input  logic             memWait,
    output logic             fetchHold,
    output logic             decodeBubble,
    output logic             pipeFreeze,
    output mipsPkg::fwdSelT  idRsFwd,
    output mipsPkg::fwdSelT  idRtFwd,
    output mipsPkg::fwdSelT  exRsFwd,
    output mipsPkg::fwdSelT  exRtFwd
);

    logic exHit;
    logic memHit;
    logic loadUse;
    logic branchOnExecute;
    logic branchOnLoad;

    // Youngest producer wins
    function automatic mipsPkg::fwdSelT pickSource(mipsPkg::regIdxT idx, mipsPkg::exMemT mem,
                                                   mipsPkg::memWbT wb);
        if (idx == '0) begin
            return mipsPkg::fwdRegister;
        end
        if (mem.regWrite && mem.dest == idx) begin
            return mipsPkg::fwdMemory;
        end
        if (wb.regWrite && wb.dest == idx) begin
            return mipsPkg::fwdWriteback;
        end
        return mipsPkg::fwdRegister;
    endfunction

    always_comb begin
        idRsFwd = pickSource(rsIdx, exMem, memWb);
        idRtFwd = pickSource(rtIdx, exMem, memWb);
        exRsFwd = pickSource(idEx.rs, exMem, memWb);
        exRtFwd = pickSource(idEx.rt, exMem, memWb);
    end

    // Decode sources that match a later stage's destination
    assign exHit  = (idEx.dest != '0) &&
                    ((rsUsed && idEx.dest == rsIdx) || (rtUsed && idEx.dest == rtIdx));
    assign memHit = (exMem.dest != '0) &&
                    ((rsUsed && exMem.dest == rsIdx) || (rtUsed && exMem.dest == rtIdx));

    assign loadUse         = idEx.memRead & exHit;
    assign branchOnExecute = isBranch & idEx.regWrite & exHit;   // Compare needs it in decode
    assign branchOnLoad    = isBranch & exMem.memRead & memHit;

    assign decodeBubble = loadUse | branchOnExecute | branchOnLoad;
    assign fetchHold    = decodeBubble;
    assign pipeFreeze   = instStall | memWait;

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/10ps

module executeStage (
    input  logic             clock,
    input  logic             rstN,
    input  mipsPkg::idExT    idEx,
    input  mipsPkg::fwdSelT  exRsFwd,
    input  mipsPkg::fwdSelT  exRtFwd,
    input  mipsPkg::wordT    memResult,
    input  mipsPkg::wordT    wbResult,
    input  logic             pipeFreeze,
    output mipsPkg::exMemT   exMem
);

    mipsPkg::wordT  opA;
    mipsPkg::wordT  rtFwdValue;
    mipsPkg::wordT  opB;
    mipsPkg::wordT  aluResult;
    mipsPkg::exMemT exMemNext;

    assign opA        = mipsPkg::pickOperand(exRsFwd, idEx.rsValue, memResult, wbResult);
    assign rtFwdValue = mipsPkg::pickOperand(exRtFwd, idEx.rtValue, memResult, wbResult);
    assign opB        = idEx.aluSrcImm ? idEx.imm : rtFwdValue;

    always_comb begin
        case (idEx.aluOp)
            mipsPkg::aluAdd:  aluResult = opA + opB;     // Wraps, no overflow trap
            mipsPkg::aluSub:  aluResult = opA - opB;
            mipsPkg::aluAnd:  aluResult = opA & opB;
            mipsPkg::aluOr:   aluResult = opA | opB;
            mipsPkg::aluXor:  aluResult = opA ^ opB;
            mipsPkg::aluSlt:  aluResult = {31'd0, $signed(opA) < $signed(opB)};
            mipsPkg::aluSltu: aluResult = {31'd0, opA < opB};
            default:          aluResult = {opB[15:0], 16'h0000};   // lui
        endcase
    end

    always_comb begin
        exMemNext.memRead   = idEx.memRead;
        exMemNext.memWrite  = idEx.memWrite;
        exMemNext.regWrite  = idEx.regWrite;
        exMemNext.memToReg  = idEx.memToReg;
        exMemNext.dest      = idEx.dest;
        exMemNext.aluResult = aluResult;
        exMemNext.storeData = rtFwdValue;
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            exMem <= '0;
        end else if (!pipeFreeze) begin
            exMem <= exMemNext;
        end
    end

endmodule

// File: rtl/memoryStage.sv
`timescale 1ns/10ps

module memoryStage (
    input  logic              clock,
    input  logic              rstN,
    input  mipsPkg::exMemT    exMem,
    input  mipsPkg::wordT     dataReadData,
    input  logic              dataReady,
    input  logic              pipeFreeze,
    output logic              dataRead,
    output logic              dataWrite,
    output mipsPkg::wordAddrT dataAddress,
    output mipsPkg::wordT     dataWriteData,
    output logic              memWait,
    output mipsPkg::wordT     memResult,
    output mipsPkg::memWbT    memWb
);

    logic          served;     // Answered while the pipe was still frozen
    mipsPkg::wordT heldData;
    mipsPkg::wordT loadData;

    assign dataRead      = exMem.memRead & ~served;
    assign dataWrite     = exMem.memWrite & ~served;
    assign dataAddress   = exMem.aluResult[31:2];
    assign dataWriteData = exMem.storeData;
    assign memWait       = (dataRead | dataWrite) & ~dataReady;
    assign memResult     = exMem.aluResult;
    assign loadData      = served ? heldData : dataReadData;

    // An instStall can outlast dataReady, so the access must not repeat
    always_ff @(posedge clock) begin
        if (!rstN) begin
            served <= 1'b0;
        end else if (!pipeFreeze) begin
            served <= 1'b0;
        end else if ((dataRead | dataWrite) & dataReady) begin
            served <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (dataRead & dataReady) begin
            heldData <= dataReadData;
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            memWb <= '0;
        end else if (!pipeFreeze) begin
            memWb.regWrite <= exMem.regWrite;
            memWb.dest     <= exMem.dest;
            memWb.value    <= exMem.memToReg ? loadData : exMem.aluResult;
        end
    end

endmodule

// File: rtl/mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
    input  logic              clock,
    input  logic              rstN,
    input  mipsPkg::wordT     instData,
    input  logic              instStall,
    input  mipsPkg::wordT     dataReadData,
    input  logic              dataReady,
    output mipsPkg::wordT     instAddress,
    output logic              dataRead,
    output logic              dataWrite,
    output mipsPkg::wordAddrT dataAddress,
    output mipsPkg::wordT     dataWriteData
);

    // Fetch to decode
    mipsPkg::wordT   decodeInst;
    mipsPkg::wordT   decodePcPlus4;
    mipsPkg::pcSelT  pcSel;
    mipsPkg::wordT   branchTarget;
    mipsPkg::wordT   jumpTarget;

    // Decode operands and hazard inputs
    mipsPkg::regIdxT rsIdx;
    mipsPkg::regIdxT rtIdx;
    logic            rsUsed;
    logic            rtUsed;
    logic            isBranch;
    mipsPkg::wordT   rsValue;
    mipsPkg::wordT   rtValue;

    mipsPkg::idExT   idEx;
    mipsPkg::exMemT  exMem;
    mipsPkg::memWbT  memWb;
    mipsPkg::wordT   memResult;
    logic            memWait;

    logic            fetchHold;
    logic            decodeBubble;
    logic            pipeFreeze;
    mipsPkg::fwdSelT idRsFwd;
    mipsPkg::fwdSelT idRtFwd;
    mipsPkg::fwdSelT exRsFwd;
    mipsPkg::fwdSelT exRtFwd;

    fetchStage u_fetchStage (
        .clock         (clock),
        .rstN          (rstN),
        .fetchHold     (fetchHold),
        .pipeFreeze    (pipeFreeze),
        .pcSel         (pcSel),
        .branchTarget  (branchTarget),
        .jumpTarget    (jumpTarget),
        .instData      (instData),
        .instStall     (instStall),
        .instAddress   (instAddress),
        .decodeInst    (decodeInst),
        .decodePcPlus4 (decodePcPlus4)
    );

    decodeControl u_decodeControl (
        .clock         (clock),
        .rstN          (rstN),
        .decodeInst    (decodeInst),
        .decodePcPlus4 (decodePcPlus4),
        .rsValue       (rsValue),
        .rtValue       (rtValue),
        .rsFwd         (idRsFwd),
        .rtFwd         (idRtFwd),
        .memResult     (memResult),
        .wbResult      (memWb.value),
        .decodeBubble  (decodeBubble),
        .pipeFreeze    (pipeFreeze),
        .rsIdx         (rsIdx),
        .rtIdx         (rtIdx),
        .rsUsed        (rsUsed),
        .rtUsed        (rtUsed),
        .isBranch      (isBranch),
        .pcSel         (pcSel),
        .branchTarget  (branchTarget),
        .jumpTarget    (jumpTarget),
        .idEx          (idEx)
    );

    registerFile u_registerFile (
        .clock   (clock),
        .rstN    (rstN),
        .rsIdx   (rsIdx),
        .rtIdx   (rtIdx),
        .memWb   (memWb),
        .rsValue (rsValue),
        .rtValue (rtValue)
    );

    hazardUnit u_hazardUnit (
        .rsIdx        (rsIdx),
        .rtIdx        (rtIdx),
        .rsUsed       (rsUsed),
        .rtUsed       (rtUsed),
        .isBranch     (isBranch),
        .idEx         (idEx),
        .exMem        (exMem),
        .memWb        (memWb),
        .instStall    (instStall),
        .memWait      (memWait),
        .fetchHold    (fetchHold),
        .decodeBubble (decodeBubble),
        .pipeFreeze   (pipeFreeze),
        .idRsFwd      (idRsFwd),
        .idRtFwd      (idRtFwd),
        .exRsFwd      (exRsFwd),
        .exRtFwd      (exRtFwd)
    );

    executeStage u_executeStage (
        .clock      (clock),
        .rstN       (rstN),
        .idEx       (idEx),
        .exRsFwd    (exRsFwd),
        .exRtFwd    (exRtFwd),
        .memResult  (memResult),
        .wbResult   (memWb.value),
        .pipeFreeze (pipeFreeze),
        .exMem      (exMem)
    );

    memoryStage u_memoryStage (
        .clock         (clock),
        .rstN          (rstN),
        .exMem         (exMem),
        .dataReadData  (dataReadData),
        .dataReady     (dataReady),
        .pipeFreeze    (pipeFreeze),
        .dataRead      (dataRead),
        .dataWrite     (dataWrite),
        .dataAddress   (dataAddress),
        .dataWriteData (dataWriteData),
        .memWait       (memWait),
        .memResult     (memResult),
        .memWb         (memWb)
    );

endmodule

// File: sim/clockGen.sv
`timescale 1ns/10ps

module clockGen (
    output logic clock,
    output logic rstN
);

    initial begin
        clock = 1'b0;
        rstN  = 1'b0;
    end

    always #2 clock = ~clock;    // 4 ns period

    // Called on a falling edge, holds reset for 8 cycles
    task automatic applyReset();
        rstN = 1'b0;
        repeat (8) @(negedge clock);
    endtask

    task automatic releaseReset();
        rstN = 1'b1;
    endtask

endmodule

// File: sim/memoryModel.sv
`timescale 1ns/10ps

module memoryModel (
    input  logic          clock,
    input  mipsPkg::wordT instAddress,
    output mipsPkg::wordT instData,
    output logic          instStall,
    input  logic          dataRead,
    input  logic          dataWrite,
    input  logic [29:0]   dataAddress,
    input  mipsPkg::wordT dataWriteData,
    output mipsPkg::wordT dataReadData,
    output logic          dataReady
);

    mipsPkg::wordT rom [0:63];
    mipsPkg::wordT ram [0:31];
    logic [29:0]   storeAddr [$];    // Write log in order
    mipsPkg::wordT storeData [$];
    logic          delaysOn;
    logic          armed;
    int            waitLeft;
    int            stallLeft;
    mipsPkg::wordT lastAddr;

    function automatic mipsPkg::wordT rType(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                            logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mipsPkg::wordT iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                            logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mipsPkg::wordT jType(logic [25:0] index);
        return {6'h02, index};
    endfunction

    initial begin
        instStall = 1'b0;
        dataReady = 1'b0;
        delaysOn  = 1'b0;
        armed     = 1'b0;
        waitLeft  = 0;
        stallLeft = 0;
        lastAddr  = 'x;
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;    // nop
        end
        rom[0]  = iType(6'h23, 0, 1, 16'd0);      // lw $1, A
        rom[1]  = iType(6'h09, 1, 10, 16'd1);     // Uses the load right away
        rom[2]  = iType(6'h23, 0, 2, 16'd4);      // lw $2, B
        rom[3]  = rType(1, 2, 3, 6'h21);
        rom[4]  = iType(6'h2b, 0, 3, 16'd32);
        rom[5]  = rType(1, 2, 3, 6'h23);
        rom[6]  = iType(6'h2b, 0, 3, 16'd36);
        rom[7]  = rType(1, 2, 3, 6'h24);
        rom[8]  = iType(6'h2b, 0, 3, 16'd40);
        rom[9]  = rType(1, 2, 3, 6'h25);
        rom[10] = iType(6'h2b, 0, 3, 16'd44);
        rom[11] = rType(1, 2, 3, 6'h26);
        rom[12] = iType(6'h2b, 0, 3, 16'd48);
        rom[13] = rType(1, 2, 3, 6'h2a);
        rom[14] = iType(6'h2b, 0, 3, 16'd52);
        rom[15] = rType(1, 2, 3, 6'h2b);
        rom[16] = iType(6'h2b, 0, 3, 16'd56);
        rom[17] = iType(6'h09, 1, 3, 16'hfffd);
        rom[18] = iType(6'h2b, 0, 3, 16'd60);
        rom[19] = iType(6'h0f, 0, 3, 16'h1234);
        rom[20] = iType(6'h0d, 3, 3, 16'h5678);
        rom[21] = iType(6'h2b, 0, 3, 16'd64);
        rom[22] = iType(6'h2b, 0, 10, 16'd68);
        rom[23] = rType(0, 0, 4, 6'h21);          // Clear flags
        rom[24] = iType(6'h04, 1, 2, 16'd3);      // beq to 28
        rom[25] = iType(6'h0d, 4, 4, 16'h0010);   // Delay slot
        rom[26] = jType(26'd29);
        rom[28] = iType(6'h0d, 4, 4, 16'h0001);
        rom[29] = iType(6'h05, 1, 2, 16'd3);      // bne to 33
        rom[30] = iType(6'h0d, 4, 4, 16'h0020);   // Delay slot
        rom[31] = jType(26'd34);
        rom[33] = iType(6'h0d, 4, 4, 16'h0002);
        rom[34] = iType(6'h2b, 0, 4, 16'd72);
        rom[35] = rType(1, 2, 0, 6'h21);          // Write to $0
        rom[36] = iType(6'h2b, 0, 0, 16'd76);
        rom[37] = jType(26'd37);                  // Park here
    end

    assign instData     = rom[instAddress[7:2]];
    assign dataReadData = ram[dataAddress[4:0]];

    task automatic prepare(mipsPkg::wordT a, mipsPkg::wordT b, logic randomDelays);
        for (int i = 0; i < 32; i++) begin
            ram[i] = 32'ha5c3_0000 ^ i;
        end
        ram[0] = a;
        ram[1] = b;
        storeAddr.delete();
        storeData.delete();
        delaysOn  = randomDelays;
        armed     = 1'b0;
        stallLeft = 0;
        lastAddr  = 'x;
    endtask

    // Fetch stall and data response delays
    initial begin
        void'($urandom(32'h2c71_4958));
        forever begin
            @(negedge clock);
            // A new fetch address may wait up to 3 cycles
            if (instAddress !== lastAddr) begin
                lastAddr  = instAddress;
                stallLeft = delaysOn ? int'($urandom % 4) : 0;
            end else if (stallLeft != 0) begin
                stallLeft--;
            end
            instStall = (stallLeft != 0);

            // Requests are stable until the next rising edge
            if (dataRead === 1'b1 || dataWrite === 1'b1) begin
                if (!armed) begin
                    armed    = 1'b1;
                    waitLeft = delaysOn ? int'($urandom % 4) : 0;
                end
                if (waitLeft == 0) begin
                    dataReady = 1'b1;
                    armed     = 1'b0;
                    if (dataWrite === 1'b1) begin
                        ram[dataAddress[4:0]] = dataWriteData;
                        storeAddr.push_back(dataAddress);
                        storeData.push_back(dataWriteData);
                    end
                end else begin
                    dataReady = 1'b0;
                    waitLeft--;
                end
            end else begin
                dataReady = 1'b0;
                armed     = 1'b0;
            end
        end
    end

endmodule

// File: sim/mipsCoreTb.sv
`timescale 1ns/10ps

module mipsCoreTb;

    logic              clock;
    logic              rstN;
    mipsPkg::wordT     instData;
    logic              instStall;
    mipsPkg::wordT     dataReadData;
    logic              dataReady;
    mipsPkg::wordT     instAddress;
    logic              dataRead;
    logic              dataWrite;
    mipsPkg::wordAddrT dataAddress;
    mipsPkg::wordT     dataWriteData;

    // A, B, then the twelve stored words
    mipsPkg::wordT vectors [0:4][0:13];

    clockGen u_clockGen (.clock(clock), .rstN(rstN));

    memoryModel u_memoryModel (
        .clock(clock), .instAddress(instAddress), .instData(instData),
        .instStall(instStall), .dataRead(dataRead), .dataWrite(dataWrite),
        .dataAddress(dataAddress), .dataWriteData(dataWriteData),
        .dataReadData(dataReadData), .dataReady(dataReady)
    );

    mipsCore u_mipsCore (
        .clock(clock), .rstN(rstN), .instData(instData), .instStall(instStall),
        .dataReadData(dataReadData), .dataReady(dataReady), .instAddress(instAddress),
        .dataRead(dataRead), .dataWrite(dataWrite), .dataAddress(dataAddress),
        .dataWriteData(dataWriteData)
    );

    task automatic stopWithError(string text);
        $display("%s", text);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(string name, mipsPkg::wordT got, mipsPkg::wordT expected);
        assert (got === expected) else begin
            stopWithError($sformatf("CHECK FAILED %s got %h expected %h", name, got, expected));
        end
    endtask

    initial begin
        int cycles;
        vectors[0] = '{32'h5, 32'h5, 32'ha, 32'h0, 32'h5, 32'h5, 32'h0, 32'h0, 32'h0,
                       32'h2, 32'h1234_5678, 32'h6, 32'h31, 32'h0};
        vectors[1] = '{32'hffff_fffe, 32'h3, 32'h1, 32'hffff_fffb, 32'h2, 32'hffff_ffff,
                       32'hffff_fffd, 32'h1, 32'h0, 32'hffff_fffb, 32'h1234_5678,
                       32'hffff_ffff, 32'h32, 32'h0};
        vectors[2] = '{32'h7fff_ffff, 32'h1, 32'h8000_0000, 32'h7fff_fffe, 32'h1,
                       32'h7fff_ffff, 32'h7fff_fffe, 32'h0, 32'h0, 32'h7fff_fffc,
                       32'h1234_5678, 32'h8000_0000, 32'h32, 32'h0};
        vectors[3] = '{32'h8000_0000, 32'h8000_0000, 32'h0, 32'h0, 32'h8000_0000,
                       32'h8000_0000, 32'h0, 32'h0, 32'h0, 32'h7fff_fffd, 32'h1234_5678,
                       32'h8000_0001, 32'h31, 32'h0};
        vectors[4] = '{32'h3, 32'hffff_ffff, 32'h2, 32'h4, 32'h3, 32'hffff_ffff,
                       32'hffff_fffc, 32'h0, 32'h1, 32'h0, 32'h1234_5678, 32'h4, 32'h32,
                       32'h0};

        for (int row = 0; row < 5; row++) begin
            @(negedge clock);
            u_memoryModel.prepare(vectors[row][0], vectors[row][1], row != 0);
            u_clockGen.applyReset();
            checkValue("dataRead", {31'd0, dataRead}, 32'd0);
            checkValue("dataWrite", {31'd0, dataWrite}, 32'd0);
            checkValue("instAddress", instAddress, mipsPkg::resetVector);
            u_clockGen.releaseReset();
            if (row == 0) begin
                // No stalls yet, the load-use bubble comes on the third fetch
                @(negedge clock);
                checkValue("instAddress", instAddress, mipsPkg::resetVector + 32'd4);
                @(negedge clock);
                checkValue("instAddress", instAddress, mipsPkg::resetVector + 32'd8);
            end
            cycles = 0;
            while (u_memoryModel.storeAddr.size() < 12) begin
                @(negedge clock);
                cycles++;
                if (cycles > 600) begin
                    stopWithError($sformatf("Timed out waiting for stores in row %0d", row));
                end
            end
            for (int i = 0; i < 12; i++) begin
                checkValue($sformatf("dataAddress[%0d]", i),
                           {2'b00, u_memoryModel.storeAddr[i]}, 32'd8 + i);
                checkValue($sformatf("dataWriteData[%0d]", i),
                           u_memoryModel.storeData[i], vectors[row][i + 2]);
            end
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: mipsCore.f
common/mipsPkg.sv
rtl/fetchStage.sv
decode/decodeControl.sv
decode/registerFile.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/mipsCore.sv
sim/clockGen.sv
sim/memoryModel.sv
sim/mipsCoreTb.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module mipsCoreTb -f mipsCore.f \
    --Mdir obj_dir -o mipsCoreSim

./obj_dir/mipsCoreSim | tee sim.log || true

if grep -qx "Finished with no errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
